//--- hw/machine_csr_file.sv
`default_nettype none
`timescale 1ns/100ps
`include "prv_cfg.svh"

module machine_csr_file (
  input  logic                        CLK,
  input  logic                        nRST,
  input  machine_csr_pkg::wb_req_t    wb_i,
  output machine_csr_pkg::wb_rsp_t    wb_o,
  input  machine_csr_pkg::trap_upd_t  upd,
  output machine_csr_pkg::trap_csr_t  csr,
  output logic [`PRV_XLEN-1:0]        mtvec
);

  machine_csr_pkg::mstatus_t mstatus_q;
  machine_csr_pkg::mie_t     mie_q;
  machine_csr_pkg::mip_t     mip_q;
  logic [`PRV_XLEN-1:0]      mtvec_q;
  logic [`PRV_XLEN-1:0]      mepc_q;
  machine_csr_pkg::mcause_t  mcause_q;
  logic [`PRV_XLEN-1:0]      mbadaddr_q;

  logic                      ack_q;     // One cycle ack
  logic [`PRV_XLEN-1:0]      rdat_q;    // Read data, valid with ack
  logic [`PRV_XLEN-1:0]      rdat_mux;
  logic                      bus_req;   // New transfer this cycle
  logic                      wr_en;
  logic                      sel_mstatus, sel_mie, sel_mip, sel_mtvec;
  logic                      sel_mepc, sel_mcause, sel_mbadaddr;

  // Keep only the global enable
  function automatic machine_csr_pkg::mstatus_t mstatus_wr(input logic [`PRV_XLEN-1:0] d);
    machine_csr_pkg::mstatus_t m;
    m    = '0;
    m.ie = d[0];
    return m;
  endfunction

  // Keep only the three machine enables
  function automatic machine_csr_pkg::mie_t mie_wr(input logic [`PRV_XLEN-1:0] d);
    machine_csr_pkg::mie_t m;
    m      = '0;
    m.msie = d[`PRV_MSI_BIT];
    m.mtie = d[`PRV_MTI_BIT];
    m.meie = d[`PRV_MEI_BIT];
    return m;
  endfunction

  // Transfer starts on cyc and stb, not again while acking
  assign bus_req = wb_i.cyc & wb_i.stb & ~ack_q;
  assign wr_en   = bus_req & wb_i.we;

  // Address decode
  assign sel_mstatus  = (wb_i.adr == machine_csr_pkg::MSTATUS);
  assign sel_mie      = (wb_i.adr == machine_csr_pkg::MIE);
  assign sel_mip      = (wb_i.adr == machine_csr_pkg::MIP);
  assign sel_mtvec    = (wb_i.adr == machine_csr_pkg::MTVEC);
  assign sel_mepc     = (wb_i.adr == machine_csr_pkg::MEPC);
  assign sel_mcause   = (wb_i.adr == machine_csr_pkg::MCAUSE);
  assign sel_mbadaddr = (wb_i.adr == machine_csr_pkg::MBADADDR);

  // Read mux, unknown addresses give zero
  always_comb begin
    rdat_mux = '0;
    if (sel_mstatus)  rdat_mux = mstatus_q;
    if (sel_mie)      rdat_mux = mie_q;
    if (sel_mip)      rdat_mux = mip_q;
    if (sel_mtvec)    rdat_mux = mtvec_q;
    if (sel_mepc)     rdat_mux = mepc_q;
    if (sel_mcause)   rdat_mux = mcause_q;
    if (sel_mbadaddr) rdat_mux = mbadaddr_q;
  end

  // Ack at the first edge after the request, gone the next
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      ack_q <= 1'b0;
    else
      ack_q <= bus_req;
  end

  always_ff @(posedge CLK) begin
    if (bus_req)
      rdat_q <= rdat_mux;           // Captured with the ack edge
  end

  assign wb_o = '{ack: ack_q, dat: rdat_q};

  // Trap registers, hardware updates win over bus writes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_q  <= `PRV_MSTATUS_RESET;
      mie_q      <= '0;
      mip_q      <= '0;
      mtvec_q    <= `PRV_MTVEC_RESET;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mbadaddr_q <= '0;
    end else begin
      if (upd.mstatus_rup)
        mstatus_q <= upd.mstatus_next;
      else if (wr_en && sel_mstatus)
        mstatus_q <= mstatus_wr(wb_i.dat);

      if (wr_en && sel_mie)
        mie_q <= mie_wr(wb_i.dat);  // Software only

      if (upd.mip_rup)
        mip_q <= upd.mip_next;
      else if (wr_en && sel_mip)
        mip_q.msip <= wb_i.dat[`PRV_MSI_BIT];  // Timer and ext bits are hardware owned

      if (wr_en && sel_mtvec)
        mtvec_q <= {wb_i.dat[`PRV_XLEN-1:2], 2'b00};  // Word aligned, direct mode

      if (upd.mepc_rup)
        mepc_q <= upd.mepc_next;
      else if (wr_en && sel_mepc)
        mepc_q <= wb_i.dat;

      if (upd.mcause_rup)
        mcause_q <= upd.mcause_next;
      else if (wr_en && sel_mcause)
        mcause_q <= wb_i.dat;       // Whole word writable

      if (upd.mbadaddr_rup)
        mbadaddr_q <= upd.mbadaddr_next;
      else if (wr_en && sel_mbadaddr)
        mbadaddr_q <= wb_i.dat;
    end
  end

  // View for the trap control
  assign csr = '{mstatus: mstatus_q, mie: mie_q, mip: mip_q};
  assign mtvec = mtvec_q;

endmodule
`default_nettype wire

//--- hw/machine_csr_pkg.sv
`default_nettype none
`include "prv_cfg.svh"

package machine_csr_pkg;

  // Simplified mstatus, only the global interrupt enable
  typedef struct packed {
    logic [`PRV_XLEN-2:0] zero;   // Reads as zero
    logic                 ie;
  } mstatus_t;

  // Interrupt enables
  typedef struct packed {
    logic [19:0] zero_hi;
    logic        meie;            // Bit 11
    logic [2:0]  zero_ext;
    logic        mtie;            // Bit 7
    logic [2:0]  zero_tim;
    logic        msie;            // Bit 3
    logic [2:0]  zero_lo;
  } mie_t;

  // Interrupt pending bits, same layout as mie
  typedef struct packed {
    logic [19:0] zero_hi;
    logic        meip;
    logic [2:0]  zero_ext;
    logic        mtip;
    logic [2:0]  zero_tim;
    logic        msip;
    logic [2:0]  zero_lo;
  } mip_t;

  // Trap cause register
  typedef struct packed {
    logic                  interrupt;  // Bit 31
    rv32_trap_pkg::cause_u cause;
  } mcause_t;

  // CSR view used by the trap control
  typedef struct packed {
    mstatus_t mstatus;
    mie_t     mie;
    mip_t     mip;
  } trap_csr_t;

  // Hardware update strobes and next values
  typedef struct packed {
    logic                 mstatus_rup;
    mstatus_t             mstatus_next;
    logic                 mip_rup;
    mip_t                 mip_next;
    logic                 mepc_rup;
    logic [`PRV_XLEN-1:0] mepc_next;
    logic                 mcause_rup;
    mcause_t              mcause_next;
    logic                 mbadaddr_rup;
    logic [`PRV_XLEN-1:0] mbadaddr_next;
  } trap_upd_t;

  // CSR addresses
  localparam logic [`PRV_CSR_ADR_W-1:0] MSTATUS  = 12'h300;
  localparam logic [`PRV_CSR_ADR_W-1:0] MIE      = 12'h304;
  localparam logic [`PRV_CSR_ADR_W-1:0] MTVEC    = 12'h305;
  localparam logic [`PRV_CSR_ADR_W-1:0] MEPC     = 12'h341;
  localparam logic [`PRV_CSR_ADR_W-1:0] MCAUSE   = 12'h342;
  localparam logic [`PRV_CSR_ADR_W-1:0] MBADADDR = 12'h343;
  localparam logic [`PRV_CSR_ADR_W-1:0] MIP      = 12'h344;

  // Wishbone classic request, master to slave
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`PRV_CSR_ADR_W-1:0] adr;
    logic [`PRV_XLEN-1:0]      dat;
  } wb_req_t;

  // Wishbone classic response
  typedef struct packed {
    logic                 ack;
    logic [`PRV_XLEN-1:0] dat;
  } wb_rsp_t;

endpackage
`default_nettype wire

//--- hw/prv_block.sv
`default_nettype none
`timescale 1ns/100ps

module prv_block (
  input  logic                         CLK,
  input  logic                         nRST,
  input  rv32_trap_pkg::trap_req_t     req,    // Exception flags
  input  rv32_trap_pkg::irq_lines_t    irq,    // Interrupt lines
  input  rv32_trap_pkg::pipe_status_t  pipe,
  input  machine_csr_pkg::wb_req_t     wb_i,   // CSR unit, bus master
  output machine_csr_pkg::wb_rsp_t     wb_o,
  output logic                         intr,   // Redirect to trap vector
  output logic [31:0]                  mtvec   // Trap target
);

  machine_csr_pkg::trap_csr_t csr_view;  // Register file to control
  machine_csr_pkg::trap_upd_t csr_upd;   // Control to register file

  // Trap decision and CSR next values
  prv_control prv_control_i (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (req),
    .irq  (irq),
    .pipe (pipe),
    .csr  (csr_view),
    .upd  (csr_upd),
    .intr (intr)
  );

  // Trap CSRs behind the Wishbone slave
  machine_csr_file machine_csr_file_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .wb_i  (wb_i),
    .wb_o  (wb_o),
    .upd   (csr_upd),
    .csr   (csr_view),
    .mtvec (mtvec)
  );

endmodule
`default_nettype wire

//--- hw/prv_cfg.svh
`ifndef PRV_CFG_SVH
`define PRV_CFG_SVH

// Data word width of the RV32 core
`define PRV_XLEN 32

// CSR address field width, fixed by the ISA
`define PRV_CSR_ADR_W 12

// Trap vector base after reset, direct mode only
`define PRV_MTVEC_RESET 32'h0000_0100

// mstatus after reset, interrupts globally disabled
`define PRV_MSTATUS_RESET 32'h0000_0000

// Bit positions of the machine interrupt sources in mie and mip
`define PRV_MSI_BIT 3
`define PRV_MTI_BIT 7
`define PRV_MEI_BIT 11
`endif

//--- hw/prv_control.sv
`default_nettype none
`timescale 1ns/100ps

module prv_control (
  input  logic                         CLK,
  input  logic                         nRST,
  input  rv32_trap_pkg::trap_req_t     req,
  input  rv32_trap_pkg::irq_lines_t    irq,
  input  rv32_trap_pkg::pipe_status_t  pipe,
  input  machine_csr_pkg::trap_csr_t   csr,
  output machine_csr_pkg::trap_upd_t   upd,
  output logic                         intr
);

  rv32_trap_pkg::ex_code_t  ex_src;     // Winning exception cause
  logic                     exception;  // Any exception flag up
  rv32_trap_pkg::int_code_t intr_src;   // Winning interrupt cause
  logic                     irq_line;   // Any interrupt line up
  logic                     interrupt_fired;
  logic                     interrupt_reg;  // Holds redirect until flush
  logic                     ret_ok;     // mret with no trap pending
  logic                     mtip_act;
  logic                     msip_act;
  logic                     meip_act;

  // Exception priority with loads first and fetch last
  always_comb begin
    exception = 1'b1;
    ex_src    = rv32_trap_pkg::INSN_MAL;
    if (req.fault_l)           ex_src = rv32_trap_pkg::L_FAULT;
    else if (req.mal_l)        ex_src = rv32_trap_pkg::L_ADDR_MAL;
    else if (req.fault_s)      ex_src = rv32_trap_pkg::S_FAULT;
    else if (req.mal_s)        ex_src = rv32_trap_pkg::S_ADDR_MAL;
    else if (req.breakpoint)   ex_src = rv32_trap_pkg::BREAKPOINT;
    else if (req.env_m)        ex_src = rv32_trap_pkg::ENV_CALL_M;
    else if (req.illegal_insn) ex_src = rv32_trap_pkg::ILLEGAL_INSN;
    else if (req.fault_insn)   ex_src = rv32_trap_pkg::INSN_FAULT;
    else if (req.mal_insn)     ex_src = rv32_trap_pkg::INSN_MAL;
    else                       exception = 1'b0;
  end

  // Pending and enabled sources
  assign mtip_act = csr.mip.mtip & csr.mie.mtie;
  assign msip_act = csr.mip.msip & csr.mie.msie;
  assign meip_act = csr.mip.meip & csr.mie.meie;

  // Interrupt cause priority is timer over soft over external
  always_comb begin
    if (mtip_act)      intr_src = rv32_trap_pkg::TIMER_INT;
    else if (msip_act) intr_src = rv32_trap_pkg::SOFT_INT;
    else               intr_src = rv32_trap_pkg::EXT_INT;
  end

  assign interrupt_fired = csr.mstatus.ie & (mtip_act | msip_act | meip_act);

  // Pending bits follow the lines one edge later
  assign irq_line    = irq.timer_int | irq.soft_int | irq.ext_int;
  assign upd.mip_rup = irq_line | irq.clear_timer_int;

  always_comb begin
    upd.mip_next = csr.mip;
    if (irq.timer_int)       upd.mip_next.mtip = 1'b1;
    if (irq.clear_timer_int) upd.mip_next.mtip = 1'b0;  // Clear wins
    if (irq.soft_int)        upd.mip_next.msip = 1'b1;
    if (irq.ext_int)         upd.mip_next.meip = 1'b1;  // Own pending bit
  end

  // Redirect now on exception or while an interrupt waits for the flush
  assign intr = exception | interrupt_reg;

  // Exception beats interrupt in the cause capture
  assign upd.mcause_rup = exception | interrupt_fired;

  always_comb begin
    upd.mcause_next.interrupt = ~exception;
    upd.mcause_next.cause.ex  = ex_src;
    if (!exception)
      upd.mcause_next.cause.intr = intr_src;  // Same word in the interrupt view
  end

  // Global enable drops on a trap and comes back on mret
  assign ret_ok          = pipe.ret & ~interrupt_reg;
  assign upd.mstatus_rup = exception | interrupt_fired | ret_ok;

  always_comb begin
    upd.mstatus_next    = '0;
    upd.mstatus_next.ie = ret_ok & ~(exception | interrupt_fired);  // Only mret sets it
  end

  // Exception PC now and interrupt PC once the pipeline has drained
  assign upd.mepc_rup  = exception | (interrupt_reg & pipe.pipe_clear);
  assign upd.mepc_next = pipe.epc;

  // Faulting address only for address and instruction faults
  assign upd.mbadaddr_rup = (req.mal_l | req.fault_l | req.mal_s | req.fault_s |
                             req.illegal_insn | req.fault_insn | req.mal_insn) &
                            pipe.pipe_clear;
  assign upd.mbadaddr_next = pipe.badaddr;

  // Request held here because ie drops the edge after firing
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      interrupt_reg <= 1'b0;
    else if (interrupt_fired)
      interrupt_reg <= 1'b1;        // Set at the edge that takes the trap
    else if (pipe.pipe_clear)
      interrupt_reg <= 1'b0;        // Released by the flush
  end

endmodule
`default_nettype wire

//--- hw/rv32_trap_pkg.sv
`default_nettype none
`include "prv_cfg.svh"

package rv32_trap_pkg;

  // Synchronous exception causes, standard RV32 codes
  typedef enum logic [`PRV_XLEN-2:0] {
    INSN_MAL     = 31'd0,   // Misaligned fetch
    INSN_FAULT   = 31'd1,   // Fetch access fault
    ILLEGAL_INSN = 31'd2,
    BREAKPOINT   = 31'd3,
    L_ADDR_MAL   = 31'd4,   // Misaligned load
    L_FAULT      = 31'd5,   // Load access fault
    S_ADDR_MAL   = 31'd6,   // Misaligned store
    S_FAULT      = 31'd7,   // Store access fault
    ENV_CALL_M   = 31'd11   // ecall from machine mode
  } ex_code_t;

  // Machine interrupt causes
  typedef enum logic [`PRV_XLEN-2:0] {
    SOFT_INT  = 31'd3,
    TIMER_INT = 31'd7,
    EXT_INT   = 31'd11
  } int_code_t;

  // mcause cause field, meaning picked by the interrupt bit
  typedef union packed {
    ex_code_t  ex;          // Interrupt bit clear
    int_code_t intr;        // Interrupt bit set
  } cause_u;

  // Exception flags from the pipeline stages
  typedef struct packed {
    logic mal_insn;
    logic fault_insn;
    logic illegal_insn;
    logic breakpoint;
    logic env_m;
    logic mal_l;
    logic fault_l;
    logic mal_s;
    logic fault_s;
  } trap_req_t;

  // Interrupt request lines
  typedef struct packed {
    logic timer_int;
    logic soft_int;
    logic ext_int;
    logic clear_timer_int;  // Timer acknowledge, beats timer_int
  } irq_lines_t;

  // Pipeline status seen by the trap unit
  typedef struct packed {
    logic                 pipe_clear;  // Pipeline drained after redirect
    logic                 ret;         // mret retired
    logic [`PRV_XLEN-1:0] epc;         // PC of the trapping instruction
    logic [`PRV_XLEN-1:0] badaddr;     // Faulting address or instruction
  } pipe_status_t;

endpackage
`default_nettype wire

//--- sim/prv_block_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "prv_cfg.svh"

module prv_block_tb;

  localparam logic [1:0] OP_NONE = 2'd0;
  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_RD   = 2'd2;   // Word read
  localparam logic [1:0] OP_RDC  = 2'd3;   // mcause read, compared as cause

  localparam logic [1:0] SRC_LIT = 2'd0;   // Expected value from the row
  localparam logic [1:0] SRC_EPC = 2'd1;   // Last epc the trap unit should hold
  localparam logic [1:0] SRC_BAD = 2'd2;   // Last badaddr it should hold

  // Exception flag masks, trap_req_t field order
  localparam logic [8:0] F_MAL_INSN   = 9'h100;
  localparam logic [8:0] F_FAULT_INSN = 9'h080;
  localparam logic [8:0] F_ILLEGAL    = 9'h040;
  localparam logic [8:0] F_BREAK      = 9'h020;
  localparam logic [8:0] F_ENV_M      = 9'h010;
  localparam logic [8:0] F_MAL_L      = 9'h008;
  localparam logic [8:0] F_FAULT_L    = 9'h004;
  localparam logic [8:0] F_MAL_S      = 9'h002;
  localparam logic [8:0] F_FAULT_S    = 9'h001;

  // Interrupt line masks
  localparam logic [3:0] I_TIMER     = 4'h8;
  localparam logic [3:0] I_SOFT      = 4'h4;
  localparam logic [3:0] I_EXT       = 4'h2;
  localparam logic [3:0] I_CLR_TIMER = 4'h1;

  localparam int ACK_WAIT = 8;              // Slave acks after one edge, margin

  typedef struct packed {
    logic [8:0]                req;
    logic [3:0]                irq;
    logic                      clr;       // pipe_clear
    logic                      ret;
    logic [1:0]                op;
    logic [`PRV_CSR_ADR_W-1:0] adr;
    logic [`PRV_XLEN-1:0]      dat;       // Write data or expected read data
    logic [1:0]                src;
    logic                      cap_epc;   // Row loads mepc
    logic                      cap_bad;   // Row loads mbadaddr
    logic                      exp_intr;
  } row_t;

  logic                         CLK;
  logic                         nRST;
  rv32_trap_pkg::trap_req_t     req;
  rv32_trap_pkg::irq_lines_t    irq;
  rv32_trap_pkg::pipe_status_t  pipe;
  machine_csr_pkg::wb_req_t     wb_i;
  machine_csr_pkg::wb_rsp_t     wb_o;
  logic                         intr;
  logic [`PRV_XLEN-1:0]         mtvec;

  row_t                 rows[$];
  logic                 table_ready;
  integer               seed;
  logic [`PRV_XLEN-1:0] epc_exp;
  logic [`PRV_XLEN-1:0] bad_exp;

  prv_block prv_block_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .req   (req),
    .irq   (irq),
    .pipe  (pipe),
    .wb_i  (wb_i),
    .wb_o  (wb_o),
    .intr  (intr),
    .mtvec (mtvec)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;                  // 4 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act));
  endtask

  task automatic check_word(input string name, input logic [`PRV_XLEN-1:0] exp,
                            input logic [`PRV_XLEN-1:0] act);
    if (act !== exp)
      abort_run($sformatf("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_cause(input string name, input machine_csr_pkg::mcause_t exp,
                             input machine_csr_pkg::mcause_t act);
    if (act !== exp)
      abort_run($sformatf("mismatch at %0t: %s expected int=%b code=%0d actual int=%b code=%0d",
                          $time, name, exp.interrupt, exp[30:0], act.interrupt, act[30:0]));
  endtask

  task automatic push_bus(input logic [1:0] op, input logic [`PRV_CSR_ADR_W-1:0] adr,
                          input logic [`PRV_XLEN-1:0] dat, input logic [1:0] src);
    row_t r;
    r     = '0;
    r.op  = op;
    r.adr = adr;
    r.dat = dat;
    r.src = src;
    rows.push_back(r);                      // Bus rows expect intr low
  endtask

  task automatic push_trap(input logic [8:0] flags, input logic [3:0] lines, input logic clr,
                           input logic ret, input logic cap_epc, input logic cap_bad,
                           input logic exp_intr);
    row_t r;
    r          = '0;
    r.req      = flags;
    r.irq      = lines;
    r.clr      = clr;
    r.ret      = ret;
    r.cap_epc  = cap_epc;
    r.cap_bad  = cap_bad;
    r.exp_intr = exp_intr;
    rows.push_back(r);
  endtask

  task automatic build_table;
    row_t r;
    push_bus(OP_RD,  machine_csr_pkg::MSTATUS,  32'h0, SRC_LIT);  // Reset values
    push_bus(OP_RD,  machine_csr_pkg::MIE,      32'h0, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MIP,      32'h0, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MTVEC,    `PRV_MTVEC_RESET, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MEPC,     32'h0, SRC_LIT);
    push_bus(OP_RDC, machine_csr_pkg::MCAUSE,   32'h0, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MBADADDR, 32'h0, SRC_LIT);
    push_bus(OP_RD,  12'h7c0,                   32'h0, SRC_LIT);  // Unknown address
    push_bus(OP_WR,  machine_csr_pkg::MIE,      32'hffff_ffff, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MIE,      32'h0000_0888, SRC_LIT);  // Three enables
    push_bus(OP_WR,  machine_csr_pkg::MTVEC,    32'h8000_0203, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MTVEC,    32'h8000_0200, SRC_LIT);  // Low bits dropped
    push_bus(OP_WR,  machine_csr_pkg::MEPC,     32'h1234_5678, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MEPC,     32'h1234_5678, SRC_LIT);
    push_bus(OP_WR,  machine_csr_pkg::MCAUSE,   32'h8000_000b, SRC_LIT);
    push_bus(OP_RDC, machine_csr_pkg::MCAUSE,   32'h8000_000b, SRC_LIT);
    push_bus(OP_WR,  12'h7c0,                   32'hdead_beef, SRC_LIT);
    push_bus(OP_RD,  12'h7c0,                   32'h0, SRC_LIT);
    push_bus(OP_WR,  machine_csr_pkg::MSTATUS,  32'hffff_ffff, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MSTATUS,  32'h1, SRC_LIT);      // Only ie sticks
    push_trap(F_FAULT_L | F_MAL_L | F_FAULT_S | F_ILLEGAL, 4'h0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
    push_bus(OP_RDC, machine_csr_pkg::MCAUSE,   {1'b0, rv32_trap_pkg::L_FAULT}, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MSTATUS,  32'h0, SRC_LIT);      // ie dropped by trap
    push_bus(OP_RD,  machine_csr_pkg::MBADADDR, 32'h0, SRC_BAD);
    push_bus(OP_RD,  machine_csr_pkg::MEPC,     32'h0, SRC_EPC);
    push_trap(F_MAL_S | F_BREAK | F_ENV_M | F_MAL_INSN, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    push_bus(OP_RDC, machine_csr_pkg::MCAUSE,   {1'b0, rv32_trap_pkg::S_ADDR_MAL}, SRC_LIT);
    push_trap(F_BREAK | F_ENV_M | F_ILLEGAL | F_FAULT_INSN, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    push_bus(OP_RDC, machine_csr_pkg::MCAUSE,   {1'b0, rv32_trap_pkg::BREAKPOINT}, SRC_LIT);
    push_trap(F_ENV_M | F_ILLEGAL | F_MAL_INSN, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    push_bus(OP_RDC, machine_csr_pkg::MCAUSE,   {1'b0, rv32_trap_pkg::ENV_CALL_M}, SRC_LIT);
    push_trap(F_FAULT_INSN | F_MAL_INSN, 4'h0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
    push_bus(OP_RDC, machine_csr_pkg::MCAUSE,   {1'b0, rv32_trap_pkg::INSN_FAULT}, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MBADADDR, 32'h0, SRC_BAD);
    push_bus(OP_RD,  machine_csr_pkg::MEPC,     32'h0, SRC_EPC);
    r          = '0;                         // Bus write races a breakpoint
    r.req      = F_BREAK;
    r.op       = OP_WR;
    r.adr      = machine_csr_pkg::MCAUSE;
    r.dat      = 32'h8000_0007;
    r.cap_epc  = 1'b1;
    r.exp_intr = 1'b1;
    rows.push_back(r);
    push_bus(OP_RDC, machine_csr_pkg::MCAUSE,   {1'b0, rv32_trap_pkg::BREAKPOINT}, SRC_LIT);
    push_bus(OP_WR,  machine_csr_pkg::MSTATUS,  32'h1, SRC_LIT);      // Interrupts on
    push_trap(9'h0, I_TIMER | I_SOFT, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    push_trap(9'h0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);  // Latched two edges after lines
    push_trap(9'h0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);  // Held, no flush yet
    push_trap(9'h0, 4'h0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);  // Flush takes epc
    push_bus(OP_RDC, machine_csr_pkg::MCAUSE,   {1'b1, rv32_trap_pkg::TIMER_INT}, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MEPC,     32'h0, SRC_EPC);
    push_bus(OP_RD,  machine_csr_pkg::MSTATUS,  32'h0, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MIP,      32'h0000_0088, SRC_LIT);
    push_trap(9'h0, I_TIMER | I_CLR_TIMER, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    push_bus(OP_RD,  machine_csr_pkg::MIP,      32'h0000_0008, SRC_LIT);  // mtip cleared
    push_bus(OP_WR,  machine_csr_pkg::MIP,      32'h0, SRC_LIT);
    push_bus(OP_RD,  machine_csr_pkg::MIP,      32'h0, SRC_LIT);
    push_trap(9'h0, 4'h0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);  // mret
    push_bus(OP_RD,  machine_csr_pkg::MSTATUS,  32'h1, SRC_LIT);
    push_bus(OP_WR,  machine_csr_pkg::MSTATUS,  32'h0, SRC_LIT);
    push_trap(9'h0, I_TIMER | I_SOFT | I_EXT, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    push_trap(9'h0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);  // Pending only, ie clear
    push_bus(OP_RD,  machine_csr_pkg::MIP,      32'h0000_0888, SRC_LIT);
  endtask

  task automatic apply_row(input row_t r);
    logic [`PRV_XLEN-1:0] epc_val;
    logic [`PRV_XLEN-1:0] bad_val;
    logic [`PRV_XLEN-1:0] exp_val;
    int                   n;
    epc_val = $random(seed);
    bad_val = $random(seed);
    @(posedge CLK);
    req             <= r.req;
    irq             <= r.irq;
    pipe.pipe_clear <= r.clr;
    pipe.ret        <= r.ret;
    pipe.epc        <= epc_val;
    pipe.badaddr    <= bad_val;
    if (r.op != OP_NONE) begin
      wb_i.cyc <= 1'b1;
      wb_i.stb <= 1'b1;
      wb_i.we  <= (r.op == OP_WR);
      wb_i.adr <= r.adr;
      wb_i.dat <= r.dat;
    end
    @(negedge CLK);
    check_bit("intr", r.exp_intr, intr);   // Exceptions redirect in the same cycle
    @(posedge CLK);
    req  <= '0;
    irq  <= '0;
    pipe <= '0;
    if (r.cap_epc)
      epc_exp = epc_val;
    if (r.cap_bad)
      bad_exp = bad_val;
    if (r.op != OP_NONE) begin
      n = 0;
      @(negedge CLK);
      while (!wb_o.ack && n < ACK_WAIT) begin
        n++;
        @(negedge CLK);
      end
      if (!wb_o.ack) begin
        abort_run($sformatf("CSR slave never acked the transfer to address %h", r.adr));
      end else begin
        case (r.src)
          SRC_EPC: exp_val = epc_exp;
          SRC_BAD: exp_val = bad_exp;
          default: exp_val = r.dat;
        endcase
        if (r.op == OP_RD)
          check_word($sformatf("wb_o.dat @%h", r.adr), exp_val, wb_o.dat);
        if (r.op == OP_RDC)
          check_cause("mcause", exp_val, wb_o.dat);
        @(posedge CLK);
        wb_i <= '0;                         // Master drops the request after ack
        @(negedge CLK);
        check_bit("wb_o.ack", 1'b0, wb_o.ack);  // Single ack per transfer
      end
    end
  endtask

  initial begin
    int i;
    seed        = 32'h8dbc;
    table_ready = 1'b0;
    epc_exp     = '0;
    bad_exp     = '0;
    nRST        = 1'b0;
    req         = '0;
    irq         = '0;
    pipe        = '0;
    wb_i        = '0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_bit("intr", 1'b0, intr);
    check_bit("wb_o.ack", 1'b0, wb_o.ack);
    check_word("mtvec", `PRV_MTVEC_RESET, mtvec);
    for (i = 0; i < rows.size(); i++)
      apply_row(rows[i]);
    $display("Everything OK");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    int limit;
    wait (table_ready);
    limit = rows.size() * 20 + 64;
    repeat (limit) @(posedge CLK);
    abort_run($sformatf("Run did not finish within %0d clock cycles", limit));
  end

endmodule
`default_nettype wire

//--- tb.f
+incdir+hw
hw/rv32_trap_pkg.sv
hw/machine_csr_pkg.sv
hw/prv_control.sv
hw/machine_csr_file.sv
hw/prv_block.sv
sim/prv_block_tb.sv
